// ==== verilog/alu_ops_pkg.sv ====
/*
 * Shared definitions for the ALU-ops configuration loader
 * Widths and FIFO sizing, buffer class and opcode enums,
 * sequencer states, FIFO entry and configuration structs
 */

package alu_ops_pkg;

    // --------------------
    // Widths and sizing
    // --------------------
    localparam int DATA_W          = 32;
    localparam int OFFSET_W        = 16;
    localparam int SHIFT_W         = 4;
    localparam int CFG_WORD_COUNT  = 6;
    localparam int WORD_INDEX_W    = 3;
    localparam int NUM_FIELDS      = 4;
    localparam int OPS_MASK_W      = NUM_FIELDS * NUM_FIELDS;
    localparam int ID_W            = 2;
    localparam int IN_FIFO_DEPTH   = 16;
    localparam int OUT_FIFO_DEPTH  = 8;
    localparam int OUT_PROG_THRESH = 6;

    // --------------------
    // Enums
    // --------------------
    typedef enum logic [2:0] {
        BUF_INVALID,
        BUF_CU_SETUP,
        BUF_ENGINE_SETUP,
        BUF_EDGE_DATA,
        BUF_VERTEX_DATA
    } buffer_class_t;

    typedef enum logic [2:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_ACC,
        ALU_DIV,
        ALU_GT,
        ALU_EQ
    } alu_operation_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_COLLECT,
        SEQ_COMMIT
    } seq_state_t;

    // --------------------
    // Structs
    // --------------------
    // Input FIFO entry, index relative to the engine window
    typedef struct packed {
        logic [WORD_INDEX_W-1:0] index;
        logic [DATA_W-1:0]       data;
    } setup_word_t;

    typedef struct packed {
        logic [ID_W-1:0] id_cu;
        logic [ID_W-1:0] id_bundle;
        logic [ID_W-1:0] id_lane;
        logic [ID_W-1:0] id_engine;
        logic [ID_W-1:0] id_module;
        logic [ID_W-1:0] id_buffer;
    } alu_dest_t;

    typedef struct packed {
        alu_operation_t        alu_operation;
        logic [NUM_FIELDS-1:0] alu_mask;
        logic [NUM_FIELDS-1:0] const_mask;
        logic [DATA_W-1:0]     const_value;
        logic [OPS_MASK_W-1:0] ops_mask;
        alu_dest_t             dest;
    } alu_ops_config_t;

endpackage

// ==== verilog/setup_word_if.sv ====
/*
 * Setup word bus between sequencer and field decoder
 * Load strobe, slot index, data word and clear
 */
`timescale 1ns/1ns

interface setup_word_if;
    import alu_ops_pkg::*;

    logic                    load;
    logic [WORD_INDEX_W-1:0] index;
    logic [DATA_W-1:0]       data;
    // Start of a new configuration
    logic                    clear;

    modport sequencer (
        output load, index, data, clear
    );

    modport decoder (
        input load, index, data, clear
    );

endinterface

// ==== verilog/packet_fifo.sv ====
/*
 * Synchronous FIFO
 * Show-ahead read port, empty, full and programmable-full flags
 */
`timescale 1ns/1ns

module packet_fifo #(
    parameter int width       = 8,
    parameter int depth       = 16,
    parameter int prog_thresh = 12
) (
    input  logic             ap_clk,
    input  logic             areset_alu_ops_generator,
    input  logic             push,
    input  logic             pop,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    logic [width-1:0]           mem [depth];
    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    // Push while full and pop while empty are dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry visible whenever not empty
    assign dout      = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (int'(count) == depth);
    assign prog_full = (int'(count) >= prog_thresh);

endmodule

// ==== verilog/setup_filter.sv ====
/*
 * Response input stage
 * Registers the response, derives its sequence number and
 * pushes setup words inside the engine window with their index
 */
`timescale 1ns/1ns

module setup_filter #(
    parameter int unsigned seq_base = 0
) (
    input  logic                       ap_clk,
    input  logic                       areset_alu_ops_generator,
    input  logic                       resp_valid,
    input  alu_ops_pkg::buffer_class_t resp_buffer,
    input  logic [alu_ops_pkg::OFFSET_W-1:0] resp_offset,
    input  logic [alu_ops_pkg::SHIFT_W-1:0]  resp_shift,
    input  logic [alu_ops_pkg::DATA_W-1:0]   resp_data,
    output logic                       push,
    output alu_ops_pkg::setup_word_t   word
);
    import alu_ops_pkg::*;

    logic                valid_q;
    buffer_class_t       buffer_q;
    logic [OFFSET_W-1:0] offset_q;
    logic [SHIFT_W-1:0]  shift_q;
    logic [DATA_W-1:0]   data_q;
    logic [OFFSET_W-1:0] seq_num;
    logic [OFFSET_W-1:0] seq_rel;
    logic                is_setup;
    logic                in_window;

    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        buffer_q <= resp_buffer;
        offset_q <= resp_offset;
        shift_q  <= resp_shift;
        data_q   <= resp_data;
    end

    assign seq_num = offset_q >> shift_q;
    assign seq_rel = seq_num - OFFSET_W'(seq_base);

    // Only CU and engine setup classes carry configuration words
    assign is_setup  = (buffer_q == BUF_CU_SETUP) || (buffer_q == BUF_ENGINE_SETUP);
    assign in_window = (seq_num >= OFFSET_W'(seq_base)) && (seq_rel < OFFSET_W'(CFG_WORD_COUNT));

    assign push       = valid_q & is_setup & in_window;
    assign word.index = seq_rel[WORD_INDEX_W-1:0];
    assign word.data  = data_q;

endmodule

// ==== verilog/config_sequencer.sv ====
/*
 * Configuration sequencer FSM
 * Pops setup words, assigns slots, clears and commits configurations
 */
`timescale 1ns/1ns

module config_sequencer (
    input  logic                     ap_clk,
    input  logic                     areset_alu_ops_generator,
    input  alu_ops_pkg::setup_word_t in_word,
    input  logic                     in_empty,
    input  logic                     out_prog_full,
    output logic                     in_pop,
    output logic                     commit,
    setup_word_if.sequencer          word_bus
);
    import alu_ops_pkg::*;

    seq_state_t              state;
    logic [WORD_INDEX_W-1:0] slot;
    logic                    start;

    // --------------------
    // Pop and slot control
    // --------------------
    // No pop during commit, the register is being pushed
    assign in_pop = ~in_empty & ~out_prog_full & (state != SEQ_COMMIT);
    assign start  = in_pop & (state == SEQ_IDLE) & (in_word.index == '0);
    assign commit = (state == SEQ_COMMIT);

    always_comb begin
        word_bus.clear = start;
        word_bus.load  = start | (in_pop & (state == SEQ_COLLECT));
        word_bus.index = slot;
        word_bus.data  = in_word.data;
    end

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            state <= SEQ_IDLE;
            slot  <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    // Words without index 0 are dropped here
                    if (start) begin
                        slot  <= WORD_INDEX_W'(1);
                        state <= SEQ_COLLECT;
                    end
                end
                SEQ_COLLECT: begin
                    if (in_pop) begin
                        slot <= slot + 1'b1;
                        if (slot == WORD_INDEX_W'(CFG_WORD_COUNT - 1)) begin
                            state <= SEQ_COMMIT;
                        end
                    end
                end
                SEQ_COMMIT: begin
                    slot  <= '0;
                    state <= SEQ_IDLE;
                end
                default: begin
                    slot  <= '0;
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== verilog/config_field_decoder.sv ====
/*
 * Configuration field decoder
 * Holds the configuration register and writes one slot per load
 */
`timescale 1ns/1ns

module config_field_decoder (
    input  logic                         ap_clk,
    input  logic                         areset_alu_ops_generator,
    setup_word_if.decoder                word_bus,
    output alu_ops_pkg::alu_ops_config_t alu_config
);
    import alu_ops_pkg::*;

    alu_ops_config_t cfg;
    alu_ops_config_t cfg_next;

    // --------------------
    // Slot field unpacking
    // --------------------
    always_comb begin
        cfg_next = word_bus.clear ? '0 : cfg;
        if (word_bus.load) begin
            case (word_bus.index)
                WORD_INDEX_W'(0): begin
                    cfg_next.alu_operation = alu_operation_t'(word_bus.data[2:0]);
                end
                WORD_INDEX_W'(1): begin
                    cfg_next.alu_mask       = word_bus.data[NUM_FIELDS-1:0];
                    cfg_next.dest.id_module = word_bus.data[NUM_FIELDS +: ID_W];
                    cfg_next.dest.id_engine = word_bus.data[NUM_FIELDS + ID_W +: ID_W];
                end
                WORD_INDEX_W'(2): begin
                    cfg_next.const_mask = word_bus.data[NUM_FIELDS-1:0];
                end
                WORD_INDEX_W'(3): begin
                    cfg_next.const_value = word_bus.data;
                end
                WORD_INDEX_W'(4): begin
                    cfg_next.ops_mask = word_bus.data[OPS_MASK_W-1:0];
                end
                WORD_INDEX_W'(5): begin
                    // Destination CU, bundle, lane, buffer from the low byte
                    cfg_next.dest.id_cu     = word_bus.data[0 +: ID_W];
                    cfg_next.dest.id_bundle = word_bus.data[ID_W +: ID_W];
                    cfg_next.dest.id_lane   = word_bus.data[2*ID_W +: ID_W];
                    cfg_next.dest.id_buffer = word_bus.data[3*ID_W +: ID_W];
                end
                default: begin
                    cfg_next = cfg_next;
                end
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_generator) begin
            cfg <= '0;
        end else if (word_bus.clear || word_bus.load) begin
            cfg <= cfg_next;
        end
    end

    assign alu_config = cfg;

endmodule

// ==== verilog/alu_ops_config_loader.sv ====
/*
 * ALU-ops configuration loader top level
 * Setup filter, input FIFO, sequencer, field decoder, output FIFO
 */
`timescale 1ns/1ns

module alu_ops_config_loader #(
    parameter int unsigned seq_base = 0
) (
    input  logic                             ap_clk,
    input  logic                             areset_alu_ops_generator,
    input  logic                             resp_valid,
    input  alu_ops_pkg::buffer_class_t       resp_buffer,
    input  logic [alu_ops_pkg::OFFSET_W-1:0] resp_offset,
    input  logic [alu_ops_pkg::SHIFT_W-1:0]  resp_shift,
    input  logic [alu_ops_pkg::DATA_W-1:0]   resp_data,
    input  logic                             config_pop,
    output logic                             config_valid,
    output alu_ops_pkg::alu_ops_config_t     alu_config
);
    import alu_ops_pkg::*;

    logic            in_push;
    setup_word_t     in_din;
    setup_word_t     in_dout;
    logic            in_pop;
    logic            in_empty;
    logic            commit;
    logic            out_empty;
    logic            out_prog_full;
    alu_ops_config_t cfg_assembled;

    setup_word_if u_setup_word_if ();

    // --------------------
    // Input side
    // --------------------
    setup_filter #(
        .seq_base (seq_base)
    ) u_setup_filter (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .resp_valid               (resp_valid),
        .resp_buffer              (resp_buffer),
        .resp_offset              (resp_offset),
        .resp_shift               (resp_shift),
        .resp_data                (resp_data),
        .push                     (in_push),
        .word                     (in_din)
    );

    // Full input FIFO drops words, the stream has no ready
    packet_fifo #(
        .width       ($bits(setup_word_t)),
        .depth       (IN_FIFO_DEPTH),
        .prog_thresh (IN_FIFO_DEPTH)
    ) u_in_fifo (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .push                     (in_push),
        .pop                      (in_pop),
        .din                      (in_din),
        .dout                     (in_dout),
        .empty                    (in_empty),
        .full                     (),
        .prog_full                ()
    );

    // --------------------
    // Control and datapath
    // --------------------
    config_sequencer u_config_sequencer (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .in_word                  (in_dout),
        .in_empty                 (in_empty),
        .out_prog_full            (out_prog_full),
        .in_pop                   (in_pop),
        .commit                   (commit),
        .word_bus                 (u_setup_word_if.sequencer)
    );

    config_field_decoder u_config_field_decoder (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .word_bus                 (u_setup_word_if.decoder),
        .alu_config               (cfg_assembled)
    );

    // --------------------
    // Output side
    // --------------------
    packet_fifo #(
        .width       ($bits(alu_ops_config_t)),
        .depth       (OUT_FIFO_DEPTH),
        .prog_thresh (OUT_PROG_THRESH)
    ) u_out_fifo (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .push                     (commit),
        .pop                      (config_pop),
        .din                      (cfg_assembled),
        .dout                     (alu_config),
        .empty                    (out_empty),
        .full                     (),
        .prog_full                (out_prog_full)
    );

    assign config_valid = ~out_empty;

endmodule

// ==== verification/alu_ops_config_loader_tb.sv ====
/*
 * Testbench for the ALU-ops configuration loader
 * Clock and reset, random setup-word stimulus with noise,
 * reference model of the slot table, comparing process, report
 */
`timescale 1ns/1ns

module alu_ops_config_loader_tb;
    import alu_ops_pkg::*;

    localparam int unsigned SEQ_BASE   = 16;
    localparam int          WAIT_LIMIT = 3000;

    logic                ap_clk = 1'b0;
    logic                areset_alu_ops_generator;
    logic                resp_valid;
    buffer_class_t       resp_buffer;
    logic [OFFSET_W-1:0] resp_offset;
    logic [SHIFT_W-1:0]  resp_shift;
    logic [DATA_W-1:0]   resp_data;
    logic                config_pop;
    logic                config_valid;
    alu_ops_config_t     alu_config;

    alu_ops_config_t     exp_q [$];
    alu_ops_config_t     exp_cfg;
    logic [DATA_W-1:0]   words [CFG_WORD_COUNT];
    logic                pop_enable;
    logic                timed_out;
    int                  errors;
    int                  received;
    int                  tests_run;
    int                  tests_failed;

    always #50 ap_clk = ~ap_clk;

    alu_ops_config_loader #(
        .seq_base (SEQ_BASE)
    ) u_alu_ops_config_loader (
        .ap_clk                   (ap_clk),
        .areset_alu_ops_generator (areset_alu_ops_generator),
        .resp_valid               (resp_valid),
        .resp_buffer              (resp_buffer),
        .resp_offset              (resp_offset),
        .resp_shift               (resp_shift),
        .resp_data                (resp_data),
        .config_pop               (config_pop),
        .config_valid             (config_valid),
        .alu_config               (alu_config)
    );

    // --------------------
    // Reference and checks
    // --------------------
    function automatic alu_ops_config_t expected_config(
        input logic [DATA_W-1:0] w [CFG_WORD_COUNT]
    );
        alu_ops_config_t c;
        c = '0;
        c.alu_operation  = alu_operation_t'(w[0][2:0]);
        c.alu_mask       = w[1][3:0];
        c.dest.id_module = w[1][5:4];
        c.dest.id_engine = w[1][7:6];
        c.const_mask     = w[2][3:0];
        c.const_value    = w[3];
        c.ops_mask       = w[4][15:0];
        c.dest.id_cu     = w[5][1:0];
        c.dest.id_bundle = w[5][3:2];
        c.dest.id_lane   = w[5][5:4];
        c.dest.id_buffer = w[5][7:6];
        return c;
    endfunction

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    // Pops the head one cycle after it was checked
    always begin
        @(negedge ap_clk);
        if (!areset_alu_ops_generator && pop_enable && config_valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected extra configuration at %0t ns", $time);
                errors++;
            end else begin
                exp_cfg = exp_q.pop_front();
                check_value(128'(alu_config), 128'(exp_cfg), "configuration contents");
            end
            received++;
            @(posedge ap_clk);
            config_pop <= 1'b1;
            @(posedge ap_clk);
            config_pop <= 1'b0;
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    // Random shift, offset low bits below the shift are don't-care
    task automatic send_word(input buffer_class_t cls, input int unsigned seq,
                             input logic [DATA_W-1:0] data);
        int unsigned shift;
        shift = $urandom_range(10, 0);
        @(posedge ap_clk);
        resp_valid  <= 1'b1;
        resp_buffer <= cls;
        resp_offset <= 16'((seq << shift) | ($urandom & ((32'd1 << shift) - 1)));
        resp_shift  <= 4'(shift);
        resp_data   <= data;
    endtask

    task automatic release_bus();
        @(posedge ap_clk);
        resp_valid <= 1'b0;
    endtask

    // Wrong class in the window, or setup class outside it
    task automatic send_noise();
        int unsigned pick;
        pick = $urandom_range(3, 0);
        if (pick == 0) begin
            send_word(BUF_EDGE_DATA, SEQ_BASE + $urandom_range(5, 0), $urandom);
        end else if (pick == 1) begin
            send_word(BUF_VERTEX_DATA, SEQ_BASE, $urandom);
        end else if (pick == 2) begin
            send_word(BUF_INVALID, SEQ_BASE + $urandom_range(5, 0), $urandom);
        end else begin
            send_word(BUF_ENGINE_SETUP,
                      $urandom_range(1, 0) ? $urandom_range(15, 0) : $urandom_range(40, 22),
                      $urandom);
        end
    endtask

    task automatic send_config(input buffer_class_t cls, input logic with_noise);
        for (int i = 0; i < CFG_WORD_COUNT; i++) begin
            words[i] = $urandom;
        end
        exp_q.push_back(expected_config(words));
        for (int i = 0; i < CFG_WORD_COUNT; i++) begin
            send_word(cls, SEQ_BASE + i, words[i]);
            if (with_noise) begin
                send_noise();
            end
        end
        release_bus();
    endtask

    // --------------------
    // Waits and reporting
    // --------------------
    // Done once nothing is expected and the output stays empty a while
    task automatic wait_drained(input string what);
        int cycles;
        int quiet;
        cycles = 0;
        quiet = 0;
        while (quiet < 8 && !timed_out) begin
            @(negedge ap_clk);
            if (exp_q.size() == 0 && !config_valid) begin
                quiet++;
            end else begin
                quiet = 0;
            end
            cycles++;
            if (cycles >= WAIT_LIMIT) begin
                $display("Timeout while waiting for %s", what);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_prog_full();
        int cycles;
        cycles = 0;
        @(negedge ap_clk);
        while (!u_alu_ops_config_loader.out_prog_full && !timed_out) begin
            @(negedge ap_clk);
            cycles++;
            if (cycles >= WAIT_LIMIT) begin
                $display("Timeout while waiting for the output FIFO to fill");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before || timed_out) begin
            tests_failed++;
            $display("Test %s: failed", name);
        end else begin
            $display("Test %s: ok", name);
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic run_tests();
        int err0;
        int rx0;

        err0 = errors;
        for (int i = 0; i < 20; i++) begin
            @(negedge ap_clk);
            check_value(128'(config_valid), 128'(0), "config_valid while idle");
        end
        finish_test("idle after reset", err0);

        err0 = errors;
        send_config(BUF_ENGINE_SETUP, 1'b0);
        wait_drained("single configuration");
        finish_test("single configuration", err0);

        err0 = errors;
        rx0 = received;
        send_config(BUF_CU_SETUP, 1'b1);
        send_config(BUF_ENGINE_SETUP, 1'b1);
        wait_drained("configurations with noise");
        check_value(128'(received - rx0), 128'(2), "configurations with noise");
        finish_test("noise filtering", err0);

        err0 = errors;
        rx0 = received;
        send_word(BUF_CU_SETUP, SEQ_BASE + 2, $urandom);
        release_bus();
        send_config(BUF_ENGINE_SETUP, 1'b0);
        wait_drained("configuration after stray word");
        check_value(128'(received - rx0), 128'(1), "configurations after stray word");
        finish_test("stray word discarded", err0);

        err0 = errors;
        rx0 = received;
        pop_enable = 1'b0;
        for (int n = 0; n < OUT_PROG_THRESH + 1; n++) begin
            send_config(($urandom & 1) ? BUF_CU_SETUP : BUF_ENGINE_SETUP, 1'b0);
        end
        wait_prog_full();
        // Words of the last configuration stay queued while stalled
        repeat (3 * CFG_WORD_COUNT) @(negedge ap_clk);
        check_value(128'(u_alu_ops_config_loader.in_empty), 128'(0),
                    "setup words queued under back-pressure");
        pop_enable = 1'b1;
        wait_drained("back-pressured configurations");
        check_value(128'(received - rx0), 128'(OUT_PROG_THRESH + 1), "configurations after stall");
        finish_test("back-pressure", err0);
    endtask

    initial begin
        areset_alu_ops_generator = 1'b1;
        resp_valid   = 1'b0;
        resp_buffer  = BUF_INVALID;
        resp_offset  = '0;
        resp_shift   = '0;
        resp_data    = '0;
        config_pop   = 1'b0;
        pop_enable   = 1'b1;
        timed_out    = 1'b0;
        errors       = 0;
        received     = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(14));
        repeat (10) @(posedge ap_clk);
        areset_alu_ops_generator <= 1'b0;
        run_tests();
        $display("Tests run: %0d, tests failed: %0d, configurations seen: %0d, errors: %0d",
                 tests_run, tests_failed, received, errors);
        if (timed_out || errors != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    end

endmodule

// ==== all.f ====
verilog/alu_ops_pkg.sv
verilog/setup_word_if.sv
verilog/packet_fifo.sv
verilog/setup_filter.sv
verilog/config_sequencer.sv
verilog/config_field_decoder.sv
verilog/alu_ops_config_loader.sv
verification/alu_ops_config_loader_tb.sv

// ==== Makefile ====
TOP = alu_ops_config_loader_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
